//--- nabp_filtered_ram.f
source/nabp_pkg.sv
source/nabp_projection_filter.sv
source/nabp_filtered_ram_bank.sv
source/nabp_filtered_swap_control.sv
source/nabp_filtered_ram_top.sv
testbench/tb_nabp_filtered_ram.sv

//--- run_sim.sh
#!/bin/sh
# build and run the filtered RAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_nabp_filtered_ram \
    -f nabp_filtered_ram.f \
    -o tb_nabp_filtered_ram
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_nabp_filtered_ram > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

//--- testbench/nabp_filtered_patterns.txt
// one angle per line with 16 raw samples followed by 16 expected filtered words
100 110 120 130 140 150 160 170 180 190 1a0 1b0 1c0 1d0 1e0 1f0 00f0 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0200
800 800 800 800 800 800 800 800 800 800 800 800 800 800 800 800 0800 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0800
123 000 000 000 000 000 000 400 000 000 000 000 000 000 000 0ff 0246 fedd 0000 0000 0000 0000 fc00 0800 fc00 0000 0000 0000 0000 0000 ff01 01fe
fff 000 fff 000 fff 000 fff 000 fff 000 fff 000 fff 000 fff 000 1ffe e002 1ffe e002 1ffe e002 1ffe e002 1ffe e002 1ffe e002 1ffe e002 1ffe f001
f00 ec0 e80 e40 e00 dc0 d80 d40 d00 cc0 c80 c40 c00 bc0 b80 b40 0f40 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0b00
000 004 010 024 040 064 090 0c4 100 144 190 1e4 240 2a4 310 384 fffc fff8 fff8 fff8 fff8 fff8 fff8 fff8 fff8 fff8 fff8 fff8 fff8 fff8 fff8 03f8

//--- testbench/tb_nabp_filtered_ram.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the filtered projection buffer
module tb_nabp_filtered_ram;
    import nabp_pkg::*;

    localparam int k_angle_count     = 6;
    localparam int k_words_per_angle = 2 * k_s_count;
    // generous per-angle budget plus start and drain
    localparam int k_cycle_limit     = k_angle_count * 60 + 200;
    localparam logic [k_angle_length-1:0] k_first_angle = 8'd10;

    logic                                clk;
    logic                                reset_n;
    logic [k_angle_length-1:0]           hs_angle;
    logic                                hs_has_next_angle;
    logic                                hs_next_angle_ack;
    logic [k_raw_length-1:0]             hs_raw;
    logic [k_s_length-1:0]               pr0_s_val;
    logic [k_s_length-1:0]               pr1_s_val;
    logic                                pr_next_angle;
    logic                                pr_done;
    logic [k_s_length-1:0]               hs_s_val;
    logic                                hs_next_angle;
    angle_tag_t                          pr0_angle;
    angle_tag_t                          pr1_angle;
    logic                                pr_next_angle_ack;
    logic signed [k_filtered_length-1:0] pr0_val;
    logic signed [k_filtered_length-1:0] pr1_val;

    // raw words then expected words, per angle
    logic [15:0] patterns [k_angle_count * k_words_per_angle];
    logic [31:0] lfsr_state;
    int          cycle_count;
    int          error_count;
    logic        host_on;
    // next angle to hand out, and the one being filled
    int          host_next;
    int          host_fill;

    nabp_filtered_ram_top i_dut
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_raw            (hs_raw),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .pr_done           (pr_done),
        .hs_s_val          (hs_s_val),
        .hs_next_angle     (hs_next_angle),
        .pr0_angle         (pr0_angle),
        .pr1_angle         (pr1_angle),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic logic [k_raw_length-1:0] raw_word(input int angle_idx, input int s);
        return patterns[angle_idx * k_words_per_angle + s][k_raw_length-1:0];
    endfunction

    function automatic logic [15:0] expected_word(input int angle_idx, input int s);
        return patterns[angle_idx * k_words_per_angle + k_s_count + s];
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // idle state, only hs_next_angle active
    task automatic check_idle(input string phase);
        check_value({phase, " hs_next_angle"}, 16'd1, 16'(hs_next_angle));
        check_value({phase, " pr_next_angle_ack"}, 16'd0, 16'(pr_next_angle_ack));
        check_value({phase, " pr0 angle valid"}, 16'd0, 16'(pr0_angle.valid));
        check_value({phase, " pr1 angle valid"}, 16'd0, 16'(pr1_angle.valid));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host RAM model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk)
    begin : host_ram
        logic [k_s_length-1:0] s_q;
        logic                  take;
        s_q  = hs_s_val;
        take = hs_next_angle && hs_next_angle_ack;
        #1;
        // one cycle read latency
        hs_raw = raw_word(host_fill, int'(s_q));
        if (take)
        begin
            host_fill = host_next;
            host_next++;
        end
        // ack held ready while angles remain
        hs_next_angle_ack = host_on && (host_next < k_angle_count);
        hs_has_next_angle = host_on && (host_next < k_angle_count);
        hs_angle          = k_first_angle + k_angle_length'(host_next);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processing model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pr0 reads s upward, pr1 downward, random idle slots
    task automatic sweep_banks(input angle_tag_t tag0, input angle_tag_t tag1);
        int                    s;
        int                    gap;
        int                    idx0;
        int                    idx1;
        logic                  due_valid;
        logic [k_s_length-1:0] due_s;
        logic                  issued_valid;
        logic [k_s_length-1:0] issued_s;
        idx0      = int'(tag0.angle) - int'(k_first_angle);
        idx1      = int'(tag1.angle) - int'(k_first_angle);
        s         = 0;
        due_valid = 1'b0;
        due_s     = '0;
        issued_s  = '0;
        while (s < k_s_count || due_valid)
        begin
            #1;
            issued_valid = 1'b0;
            if (s < k_s_count)
            begin
                draw_bits(1, gap);
                if (gap == 0)
                begin
                    pr0_s_val    = k_s_length'(s);
                    pr1_s_val    = k_s_length'(k_s_count - 1 - s);
                    issued_valid = 1'b1;
                    issued_s     = k_s_length'(s);
                    s++;
                end
            end
            @(posedge clk);
            // data of the address driven two edges back
            if (due_valid && tag0.valid)
                check_value($sformatf("pr0_val angle %0d s %0d", tag0.angle, due_s),
                            expected_word(idx0, int'(due_s)), pr0_val);
            if (due_valid && tag1.valid)
                check_value($sformatf("pr1_val angle %0d s %0d", tag1.angle,
                                      k_s_count - 1 - int'(due_s)),
                            expected_word(idx1, k_s_count - 1 - int'(due_s)), pr1_val);
            due_valid = issued_valid;
            due_s     = issued_s;
        end
    endtask

    task automatic serve_angles();
        angle_tag_t                tag0;
        angle_tag_t                tag1;
        logic [k_angle_length-1:0] last_pr0;
        logic                      prev_had_pr0;
        logic                      busy;
        int                        pr0_seen;
        int                        stall;
        last_pr0     = '0;
        prev_had_pr0 = 1'b0;
        busy         = 1'b1;
        pr0_seen     = 0;
        // first angle reaches work bank 0 after its fill
        do
            @(posedge clk);
        while (!pr0_angle.valid);
        while (busy)
        begin
            tag0 = pr0_angle;
            tag1 = pr1_angle;
            check_value("pr0 tag valid", 16'(pr0_seen < k_angle_count), 16'(tag0.valid));
            check_value("pr1 tag valid", 16'(prev_had_pr0), 16'(tag1.valid));
            if (tag0.valid)
            begin
                check_value("pr0 angle order",
                            16'(k_first_angle + k_angle_length'(pr0_seen)),
                            16'(tag0.angle));
                pr0_seen++;
            end
            // pr1 holds what pr0 showed one rotate earlier
            if (tag1.valid)
                check_value("pr1 angle follows pr0", 16'(last_pr0), 16'(tag1.angle));
            sweep_banks(tag0, tag1);
            draw_bits(2, stall);
            repeat (stall) @(posedge clk);
            prev_had_pr0 = tag0.valid;
            last_pr0     = tag0.angle;
            #1;
            if (tag0.valid)
            begin
                pr_next_angle = 1'b1;
                do
                    @(posedge clk);
                while (!pr_next_angle_ack);
                #1;
                pr_next_angle = 1'b0;
                @(posedge clk);
            end
            else
            begin
                // pipeline drained, last angle served on pr1
                pr_done = 1'b1;
                @(posedge clk);
                #1;
                pr_done = 1'b0;
                busy    = 1'b0;
            end
        end
    endtask

    // run limit
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= k_cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", k_cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        clk               = 1'b0;
        reset_n           = 1'b1;
        hs_angle          = '0;
        hs_has_next_angle = 1'b0;
        hs_next_angle_ack = 1'b0;
        hs_raw            = '0;
        pr0_s_val         = '0;
        pr1_s_val         = '0;
        pr_next_angle     = 1'b0;
        pr_done           = 1'b0;
        host_on           = 1'b0;
        host_next         = 0;
        host_fill         = 0;
        cycle_count       = 0;
        error_count       = 0;
        lfsr_state        = 32'hb72c;
        $readmemh("testbench/nabp_filtered_patterns.txt", patterns);

        // reset is active high on reset_n
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b0;
        @(posedge clk);
        check_idle("after reset");
        host_on = 1'b1;

        serve_angles();
        @(posedge clk);
        check_idle("after pr_done");

        if (error_count == 0)
        begin
            $display("STATUS: PASS");
            $finish;
        end
        else
        begin
            $display("STATUS: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- source/nabp_filtered_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

// filtered projection buffer, filter plus rotating banks
module nabp_filtered_ram_top
(
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic [nabp_pkg::k_angle_length-1:0]           hs_angle,
    input  logic                                          hs_has_next_angle,
    input  logic                                          hs_next_angle_ack,
    input  logic [nabp_pkg::k_raw_length-1:0]             hs_raw,
    input  logic [nabp_pkg::k_s_length-1:0]               pr0_s_val,
    input  logic [nabp_pkg::k_s_length-1:0]               pr1_s_val,
    input  logic                                          pr_next_angle,
    input  logic                                          pr_done,
    output logic [nabp_pkg::k_s_length-1:0]               hs_s_val,
    output logic                                          hs_next_angle,
    output nabp_pkg::angle_tag_t                          pr0_angle,
    output nabp_pkg::angle_tag_t                          pr1_angle,
    output logic                                          pr_next_angle_ack,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr0_val,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr1_val
);
    import nabp_pkg::*;

    raw_sample_t    raw_sample;
    filtered_word_t filtered;
    // host return flag, already one cycle behind the address
    logic           hs_issue;

    // address has wrapped to 0 only when s = 15 comes back
    assign raw_sample.valid = hs_issue;
    assign raw_sample.last  = hs_issue && (hs_s_val == '0);
    assign raw_sample.data  = hs_raw;

    nabp_projection_filter u_filter
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .sample_in    (raw_sample),
        .filtered_out (filtered)
    );

    nabp_filtered_swap_control u_swap
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .filtered_in       (filtered),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .pr_done           (pr_done),
        .hs_s_val          (hs_s_val),
        .hs_issue          (hs_issue),
        .hs_next_angle     (hs_next_angle),
        .pr0_angle         (pr0_angle),
        .pr1_angle         (pr1_angle),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val)
    );

endmodule

`default_nettype wire

//--- source/nabp_filtered_swap_control.sv
`timescale 1ns/1ps
`default_nettype none

// angle rotation over three filtered banks
module nabp_filtered_swap_control
(
    input  logic                                          clk,
    input  logic                                          reset_n,
    // host side
    input  logic [nabp_pkg::k_angle_length-1:0]           hs_angle,
    // high while the host still holds an angle to hand out
    input  logic                                          hs_has_next_angle,
    input  logic                                          hs_next_angle_ack,
    input  nabp_pkg::filtered_word_t                      filtered_in,
    // processing side
    input  logic [nabp_pkg::k_s_length-1:0]               pr0_s_val,
    input  logic [nabp_pkg::k_s_length-1:0]               pr1_s_val,
    input  logic                                          pr_next_angle,
    input  logic                                          pr_done,
    output logic [nabp_pkg::k_s_length-1:0]               hs_s_val,
    output logic                                          hs_issue,
    output logic                                          hs_next_angle,
    output nabp_pkg::angle_tag_t                          pr0_angle,
    output nabp_pkg::angle_tag_t                          pr1_angle,
    output logic                                          pr_next_angle_ack,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr0_val,
    output logic signed [nabp_pkg::k_filtered_length-1:0] pr1_val
);
    import nabp_pkg::*;

    swap_state_t              state;
    swap_state_t              next_state;
    logic                     rotate;
    // rotate that also takes a new angle from the host
    logic                     take_angle;
    logic [k_role_length-1:0] role_sel;
    logic [k_role_length-1:0] fill_idx;
    logic [k_role_length-1:0] w0_idx;
    logic [k_role_length-1:0] w1_idx;
    // read data returns a cycle later, mux by the roles of that cycle
    logic [k_role_length-1:0] w0_q;
    logic [k_role_length-1:0] w1_q;
    logic                     fill_kick;
    logic                     fill_done;
    // tag of the angle in the fill bank
    angle_tag_t               fill_tag;

    logic [k_bank_count-1:0]             bank_kick;
    logic [k_bank_count-1:0]             bank_issue;
    logic [k_bank_count-1:0]             bank_done;
    logic [k_s_length-1:0]               bank_host_s [k_bank_count];
    logic [k_s_length-1:0]               bank_rd_s [k_bank_count];
    logic signed [k_filtered_length-1:0] bank_rd_val [k_bank_count];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mealy outputs, rotate and acknowledges
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        rotate            = 1'b0;
        hs_next_angle     = 1'b0;
        pr_next_angle_ack = 1'b0;
        case (state)
            ready_s:
            begin
                hs_next_angle = 1'b1;
                rotate        = hs_next_angle_ack;
            end
            // first angle, nothing to process yet
            fill_s:
                if (fill_done)
                begin
                    hs_next_angle = 1'b1;
                    rotate        = hs_next_angle_ack;
                end
            fill_and_work_1_s, fill_and_work_2_s:
                if (fill_done && pr_next_angle)
                begin
                    hs_next_angle = hs_has_next_angle;
                    // no more angles, rotate anyway to drain
                    rotate            = !hs_has_next_angle || hs_next_angle_ack;
                    pr_next_angle_ack = rotate;
                end
            work_1_s:
                if (pr_next_angle)
                begin
                    rotate            = 1'b1;
                    pr_next_angle_ack = 1'b1;
                end
            default:
            begin
                rotate = 1'b0;
            end
        endcase
    end

    assign take_angle = hs_next_angle && hs_next_angle_ack;

    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (rotate)
                    next_state = fill_s;
            fill_s:
                if (rotate)
                    next_state = fill_and_work_1_s;
            fill_and_work_1_s:
                if (rotate)
                    next_state = fill_and_work_2_s;
            // steady state while angles keep coming
            fill_and_work_2_s:
                if (rotate && !hs_has_next_angle)
                    next_state = work_1_s;
            work_1_s:
                if (rotate)
                    next_state = work_2_s;
            work_2_s:
                if (pr_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // state, role select and kick
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state     <= ready_s;
            role_sel  <= '0;
            fill_kick <= 1'b0;
            w0_q      <= 2'd1;
            w1_q      <= 2'd2;
        end
        else
        begin
            state     <= next_state;
            fill_kick <= take_angle;
            w0_q      <= w0_idx;
            w1_q      <= w1_idx;
            if (rotate)
                role_sel <= (role_sel == k_role_length'(k_bank_count - 1))
                    ? '0 : role_sel + 1'b1;
        end
    end

    // angle tags shift with the banks
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            fill_tag  <= '0;
            pr0_angle <= '0;
            pr1_angle <= '0;
        end
        else if (rotate)
        begin
            fill_tag.valid <= take_angle;
            fill_tag.angle <= hs_angle;
            pr0_angle      <= fill_tag;
            pr1_angle      <= pr0_angle;
        end
        // last angle served on pr1, back to idle
        else if (state == work_2_s && pr_done)
            pr1_angle.valid <= 1'b0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // role table, fill / work 0 / work 1
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        case (role_sel)
            2'd1:
            begin
                fill_idx = 2'd2;
                w0_idx   = 2'd0;
                w1_idx   = 2'd1;
            end
            2'd2:
            begin
                fill_idx = 2'd1;
                w0_idx   = 2'd2;
                w1_idx   = 2'd0;
            end
            default:
            begin
                fill_idx = 2'd0;
                w0_idx   = 2'd1;
                w1_idx   = 2'd2;
            end
        endcase
    end

    for (genvar b = 0; b < k_bank_count; b++)
    begin : g_bank
        assign bank_kick[b] = fill_kick && (fill_idx == k_role_length'(b));
        // fill bank read port unused, pr1 address is harmless there
        assign bank_rd_s[b] = (w0_idx == k_role_length'(b)) ? pr0_s_val : pr1_s_val;

        nabp_filtered_ram_bank u_bank
        (
            .clk         (clk),
            .reset_n     (reset_n),
            .fill_kick   (bank_kick[b]),
            .filtered_in (filtered_in),
            .host_s_val  (bank_host_s[b]),
            .host_issue  (bank_issue[b]),
            .fill_done   (bank_done[b]),
            .rd_s_val    (bank_rd_s[b]),
            .rd_val      (bank_rd_val[b])
        );
    end

    assign hs_s_val = bank_host_s[fill_idx];
    assign hs_issue = bank_issue[fill_idx];
    // stale done of the previous fill still up in the kick cycle
    assign fill_done = bank_done[fill_idx] && !fill_kick;
    assign pr0_val   = bank_rd_val[w0_q];
    assign pr1_val   = bank_rd_val[w1_q];

    a_role_in_range: assert property (@(posedge clk) disable iff (reset_n)
        role_sel < k_role_length'(k_bank_count));

    // processing ack always moves the bank roles on
    a_ack_on_rotate: assert property (@(posedge clk) disable iff (reset_n)
        pr_next_angle_ack |=> role_sel != $past(role_sel));

endmodule

`default_nettype wire

//--- source/nabp_filtered_ram_bank.sv
`timescale 1ns/1ps
`default_nettype none

// one filtered bank, fill sequencer plus read port
module nabp_filtered_ram_bank
(
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          fill_kick,
    input  nabp_pkg::filtered_word_t                      filtered_in,
    output logic [nabp_pkg::k_s_length-1:0]               host_s_val,
    output logic                                          host_issue,
    output logic                                          fill_done,
    input  logic [nabp_pkg::k_s_length-1:0]               rd_s_val,
    output logic signed [nabp_pkg::k_filtered_length-1:0] rd_val
);
    import nabp_pkg::*;

    localparam logic [k_s_length-1:0] k_last_s = k_s_length'(k_s_count - 1);

    logic signed [k_filtered_length-1:0] mem [k_s_count];
    // address toward the host is live
    logic                                issuing;
    // host data for the previous address is on the bus
    logic                                issue_d;
    logic                                filling;
    logic [k_s_length-1:0]               wr_s;
    logic                                wr_en;

    // banks not filling ignore the broadcast
    assign wr_en = filtered_in.valid && filling;

    // host return flag, one cycle behind the address
    assign host_issue = issue_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            issuing    <= 1'b0;
            issue_d    <= 1'b0;
            host_s_val <= '0;
            filling    <= 1'b0;
            fill_done  <= 1'b0;
            wr_s       <= '0;
        end
        else
        begin
            issue_d <= issuing;
            if (fill_kick)
            begin
                issuing    <= 1'b1;
                host_s_val <= '0;
                filling    <= 1'b1;
                fill_done  <= 1'b0;
                wr_s       <= '0;
            end
            else
            begin
                // address wraps back to 0 after s = 15
                if (issuing)
                begin
                    host_s_val <= host_s_val + 1'b1;
                    if (host_s_val == k_last_s)
                        issuing <= 1'b0;
                end
                // own write counter, advanced by valid alone
                if (wr_en)
                begin
                    wr_s <= wr_s + 1'b1;
                    if (wr_s == k_last_s)
                    begin
                        filling   <= 1'b0;
                        fill_done <= 1'b1;
                    end
                end
            end
        end
    end

    // storage and registered read, latency 1
    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_s] <= filtered_in.data;
        rd_val <= mem[rd_s_val];
    end

    // controller only kicks a bank that is idle
    a_no_kick_mid_fill: assert property (@(posedge clk) disable iff (reset_n)
        fill_kick |-> !filling && !issuing);

endmodule

`default_nettype wire

//--- source/nabp_projection_filter.sv
`timescale 1ns/1ps
`default_nettype none

// 3-tap high-pass, y[s] = 2x[s] - x[s-1] - x[s+1]
module nabp_projection_filter
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  nabp_pkg::raw_sample_t    sample_in,
    output nabp_pkg::filtered_word_t filtered_out
);
    import nabp_pkg::*;

    // window, x_cur is the centre tap
    logic signed [k_filtered_length-1:0] x_cur;
    logic signed [k_filtered_length-1:0] x_prev;
    logic signed [k_filtered_length-1:0] x_next;
    logic signed [k_filtered_length-1:0] y;
    // x_cur holds a sample still waiting for its right neighbour
    logic                                cur_val;
    // slot after last, right neighbour taken as zero
    logic                                flush;
    logic                                out_valid;
    logic signed [k_filtered_length-1:0] out_data;

    // zero extend unsigned raw, zero when nothing arrives (flush pad)
    assign x_next = sample_in.valid
        ? {{(k_filtered_length - k_raw_length){1'b0}}, sample_in.data}
        : '0;

    // x_prev already zero at s = 0
    assign y = (x_cur <<< 1) - x_prev - x_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            cur_val   <= 1'b0;
            flush     <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            flush     <= sample_in.valid && sample_in.last;
            // emit when the right neighbour arrives, or on flush
            out_valid <= (sample_in.valid && cur_val) || flush;
            if (sample_in.valid)
                cur_val <= 1'b1;
            else if (flush)
                cur_val <= 1'b0;
        end
    end

    // window shift and result register
    always_ff @(posedge clk)
    begin
        if (sample_in.valid)
        begin
            // first sample of a row sees a zero left tap
            x_prev <= cur_val ? x_cur : '0;
            x_cur  <= x_next;
        end
        out_data <= y;
    end

    assign filtered_out.valid = out_valid;
    assign filtered_out.data  = out_data;

    // the flush slot must stay free of new samples
    a_flush_slot_free: assert property (@(posedge clk) disable iff (reset_n)
        sample_in.valid && sample_in.last |=> !sample_in.valid);

endmodule

`default_nettype wire

//--- source/nabp_pkg.sv
`default_nettype none

package nabp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and counts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int k_angle_length    = 8;
    // one projection row
    localparam int k_s_count         = 16;
    localparam int k_s_length        = 4;
    // host samples are unsigned
    localparam int k_raw_length      = 12;
    localparam int k_filtered_length = 16;
    // fill, work 0, work 1
    localparam int k_bank_count      = 3;
    localparam int k_role_length     = 2;

    // rotation controller states
    typedef enum logic [2:0] {
        ready_s,
        fill_s,
        fill_and_work_1_s,
        fill_and_work_2_s,
        work_1_s,
        work_2_s
    } swap_state_t;

    // host return, top to filter
    typedef struct packed {
        logic                    valid;
        logic                    last;
        logic [k_raw_length-1:0] data;
    } raw_sample_t;

    // filter output, broadcast to all banks
    typedef struct packed {
        logic                                valid;
        logic signed [k_filtered_length-1:0] data;
    } filtered_word_t;

    typedef struct packed {
        logic                      valid;
        logic [k_angle_length-1:0] angle;
    } angle_tag_t;

endpackage

`default_nettype wire
